//--- logic/burger_config.svh
// all values in screen pixels with origin at top left; layer count is fixed at four
`ifndef BURGER_CONFIG_SVH
`define BURGER_CONFIG_SVH

// ================================================
// screen and chef
// ================================================
`define COORD_W       10
`define CHEF_X_MAX    624  // 640 minus chef width
`define CHEF_Y_MAX    464
`define CHEF_X_START  320
`define CHEF_Y_START  400
`define CHEF_STEP     2
`define CHEF_HEIGHT   16

// ================================================
// ingredient columns
// ================================================
`define INGR_WIDTH    32
`define FALL_STEP     4
`define LAYER_GAP     16
`define LAYER_COUNT   4
`define LAND_Y0       350  // top bun lands highest
`define LAND_Y1       366
`define LAND_Y2       382
`define LAND_Y3       398
`define COL0_X        32
`define COL1_X        128
// index 0 is the top layer, so it sits in the low bits
`define COL0_Y_START  {`COORD_W'(316), `COORD_W'(252), `COORD_W'(156), `COORD_W'(92)}
`define COL1_Y_START  {`COORD_W'(316), `COORD_W'(252), `COORD_W'(188), `COORD_W'(28)}

// usb hid keycodes
`define KEY_LEFT      8'h04  // a
`define KEY_RIGHT     8'h07  // d
`define KEY_UP        8'h1A  // w
`define KEY_DOWN      8'h16  // s

`endif

//--- logic/burger_pkg.sv
// shared game types; widths follow the config header, layer 0 is the top of a column
`include "burger_config.svh"

package burger_pkg;

	// ================================================
	// chef command
	// ================================================
	typedef enum logic [2:0] {
		MOVE_NONE  = 3'd0,
		MOVE_LEFT  = 3'd1,
		MOVE_RIGHT = 3'd2,
		MOVE_UP    = 3'd3,
		MOVE_DOWN  = 3'd4
	} move_t;

	// top left corner of the chef sprite
	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} chef_pos_t;

	// ================================================
	// one burger column
	// ================================================
	typedef struct packed {
		logic [`LAYER_COUNT-1:0][`COORD_W-1:0] layer_y;  // top edge of each layer
		logic [`LAYER_COUNT-1:0]               falling;
		logic [`LAYER_COUNT-1:0]               landed;   // sticky until reset
	} column_state_t;

endpackage

//--- logic/keycode_decoder.sv
// keycode is sampled only on frame_tick; any other key or a key combination gives no move
`timescale 1ns/1ns
`include "burger_config.svh"

module keycode_decoder
	import burger_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       frame_tick,
	input  logic [7:0] keycode,
	output move_t      move
);

	move_t move_dec;

	always_comb begin
		case (keycode)
			`KEY_LEFT:  move_dec = MOVE_LEFT;
			`KEY_RIGHT: move_dec = MOVE_RIGHT;
			`KEY_UP:    move_dec = MOVE_UP;
			`KEY_DOWN:  move_dec = MOVE_DOWN;
			default:    move_dec = MOVE_NONE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			move <= MOVE_NONE;
		end else if (frame_tick) begin
			move <= move_dec;  // held for a whole frame
		end
	end

	a_move_legal: assert property (@(posedge clk) disable iff (!arst_n)
		move inside {MOVE_NONE, MOVE_LEFT, MOVE_RIGHT, MOVE_UP, MOVE_DOWN});

endmodule

//--- logic/chef_motion.sv
// one step per frame_tick, clamped to the screen; floor and ladder levels are trusted as given
`timescale 1ns/1ns
`include "burger_config.svh"

module chef_motion
	import burger_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      frame_tick,
	input  move_t     move,
	input  logic      on_floor,   // walking allowed
	input  logic      on_ladder,  // climbing allowed
	output chef_pos_t chef_pos
);

	localparam logic [`COORD_W-1:0] STEP    = `CHEF_STEP;
	localparam logic [`COORD_W-1:0] X_MAX   = `CHEF_X_MAX;
	localparam logic [`COORD_W-1:0] Y_MAX   = `CHEF_Y_MAX;
	localparam logic [`COORD_W-1:0] X_START = `CHEF_X_START;
	localparam logic [`COORD_W-1:0] Y_START = `CHEF_Y_START;

	chef_pos_t pos;
	chef_pos_t pos_next;

	// ================================================
	// gated step with edge clamp
	// ================================================
	always_comb begin
		pos_next = pos;
		case (move)
			MOVE_LEFT: begin
				if (on_floor)
					pos_next.x = (pos.x < STEP) ? '0 : pos.x - STEP;
			end
			MOVE_RIGHT: begin
				if (on_floor)
					pos_next.x = (pos.x > X_MAX - STEP) ? X_MAX : pos.x + STEP;
			end
			MOVE_UP: begin  // screen y grows downward
				if (on_ladder)
					pos_next.y = (pos.y < STEP) ? '0 : pos.y - STEP;
			end
			MOVE_DOWN: begin
				if (on_ladder)
					pos_next.y = (pos.y > Y_MAX - STEP) ? Y_MAX : pos.y + STEP;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pos.x <= X_START;
			pos.y <= Y_START;
		end else if (frame_tick) begin
			pos <= pos_next;
		end
	end

	assign chef_pos = pos;

	a_on_screen: assert property (@(posedge clk) disable iff (!arst_n)
		(chef_pos.x <= X_MAX) && (chef_pos.y <= Y_MAX));

endmodule

//--- logic/ingredient_column.sv
// four layers only; landing heights are fixed per layer and must lie below the start heights
`timescale 1ns/1ns
`include "burger_config.svh"

module ingredient_column
	import burger_pkg::*;
#(
	parameter logic [`COORD_W-1:0]                   COL_X         = `COL0_X,
	parameter logic [`LAYER_COUNT-1:0][`COORD_W-1:0] LAYER_Y_START = `COL0_Y_START
) (
	input  logic          clk,
	input  logic          arst_n,
	input  logic          frame_tick,
	input  chef_pos_t     chef_pos,
	output column_state_t state
);

	localparam logic [`LAYER_COUNT-1:0][`COORD_W-1:0] LAND_Y = {
		`COORD_W'(`LAND_Y3), `COORD_W'(`LAND_Y2), `COORD_W'(`LAND_Y1), `COORD_W'(`LAND_Y0)};

	// one spare bit so sums near the screen bottom do not wrap
	localparam logic [`COORD_W:0] CHEF_H = `CHEF_HEIGHT;
	localparam logic [`COORD_W:0] FALL   = `FALL_STEP;
	localparam logic [`COORD_W:0] GAP    = `LAYER_GAP;
	localparam logic [`COORD_W:0] X_HI   = {1'b0, COL_X} + `COORD_W'(`INGR_WIDTH - 1);

	column_state_t                       st;
	logic [`COORD_W:0]                   feet_y;
	logic                                chef_in_col;
	logic [`LAYER_COUNT-1:0]             stomp;
	logic [`LAYER_COUNT-1:0]             chain;
	logic [`LAYER_COUNT-1:0][`COORD_W:0] drop_y;

	// ================================================
	// fall triggers, all from pre-tick values
	// ================================================
	assign feet_y      = {1'b0, chef_pos.y} + CHEF_H;
	assign chef_in_col = (chef_pos.x >= COL_X) && ({1'b0, chef_pos.x} <= X_HI);

	always_comb begin
		chain[0] = 1'b0;  // nothing above the top bun
		for (int i = 1; i < `LAYER_COUNT; i++) begin
			chain[i] = st.falling[i-1] &&
				({1'b0, st.layer_y[i-1]} + GAP >= {1'b0, st.layer_y[i]});
		end
		for (int i = 0; i < `LAYER_COUNT; i++) begin
			stomp[i]  = chef_in_col && (feet_y == {1'b0, st.layer_y[i]});
			drop_y[i] = {1'b0, st.layer_y[i]} + FALL;
		end
	end

	// ================================================
	// layer state
	// ================================================
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st.layer_y <= LAYER_Y_START;
			st.falling <= '0;
			st.landed  <= '0;
		end else if (frame_tick) begin
			for (int i = 0; i < `LAYER_COUNT; i++) begin
				if (st.falling[i]) begin
					if (drop_y[i] >= {1'b0, LAND_Y[i]}) begin  // snap onto the plate
						st.layer_y[i] <= LAND_Y[i];
						st.falling[i] <= 1'b0;
						st.landed[i]  <= 1'b1;
					end else begin
						st.layer_y[i] <= drop_y[i][`COORD_W-1:0];
					end
				end else if (!st.landed[i] && (stomp[i] || chain[i])) begin
					st.falling[i] <= 1'b1;  // starts moving next frame
				end
			end
		end
	end

	assign state = st;

	for (genvar g = 0; g < `LAYER_COUNT; g++) begin : g_layer_chk
		a_not_below_land: assert property (@(posedge clk) disable iff (!arst_n)
			st.layer_y[g] <= LAND_Y[g]);
	end

	a_flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		(st.falling & st.landed) == '0);

endmodule

//--- logic/hex_display.sv
// common-anode digits, segments and point active low; shows raw hex, not decimal
`timescale 1ns/1ns

module hex_display
	import burger_pkg::*;
(
	input  chef_pos_t  chef_pos,
	output logic [7:0] hex0,
	output logic [7:0] hex1,
	output logic [7:0] hex2,
	output logic [7:0] hex3,
	output logic [7:0] hex4,
	output logic [7:0] hex5
);

	logic [11:0] x_ext;  // three nibbles per coordinate
	logic [11:0] y_ext;

	// segment order gfedcba
	function automatic logic [6:0] seg_decode(input logic [3:0] nib);
		case (nib)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

	assign x_ext = 12'(chef_pos.x);
	assign y_ext = 12'(chef_pos.y);

	// decimal point kept dark
	assign hex0 = {1'b1, seg_decode(x_ext[3:0])};
	assign hex1 = {1'b1, seg_decode(x_ext[7:4])};
	assign hex2 = {1'b1, seg_decode(x_ext[11:8])};
	assign hex3 = {1'b1, seg_decode(y_ext[3:0])};
	assign hex4 = {1'b1, seg_decode(y_ext[7:4])};
	assign hex5 = {1'b1, seg_decode(y_ext[11:8])};

endmodule

//--- logic/burger_top.sv
// game logic only; frame_tick must be a single clk cycle wide, once per video frame
`timescale 1ns/1ns
`include "burger_config.svh"

module burger_top
	import burger_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n,
	input  logic          frame_tick,
	input  logic [7:0]    keycode,
	input  logic          on_floor,
	input  logic          on_ladder,
	output chef_pos_t     chef_pos,
	output column_state_t column0,
	output column_state_t column1,
	output logic [7:0]    hex0,
	output logic [7:0]    hex1,
	output logic [7:0]    hex2,
	output logic [7:0]    hex3,
	output logic [7:0]    hex4,
	output logic [7:0]    hex5
);

	move_t move;  // one frame behind the keycode

	// ================================================
	// input side and chef
	// ================================================
	keycode_decoder u_keycode_decoder (
		.clk        (clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.keycode    (keycode),
		.move       (move)
	);

	chef_motion u_chef_motion (
		.clk        (clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.move       (move),
		.on_floor   (on_floor),
		.on_ladder  (on_ladder),
		.chef_pos   (chef_pos)
	);

	// ================================================
	// burger columns and readout
	// ================================================
	ingredient_column #(
		.COL_X         (`COL0_X),
		.LAYER_Y_START (`COL0_Y_START)
	) u_column0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.chef_pos   (chef_pos),
		.state      (column0)
	);

	ingredient_column #(
		.COL_X         (`COL1_X),
		.LAYER_Y_START (`COL1_Y_START)
	) u_column1 (
		.clk        (clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.chef_pos   (chef_pos),
		.state      (column1)
	);

	hex_display u_hex_display (
		.chef_pos (chef_pos),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2),
		.hex3     (hex3),
		.hex4     (hex4),
		.hex5     (hex5)
	);

endmodule

//--- verif/tb_burger_top.sv
// golden file is read from verif/ relative to the run directory; each line is checked after its last frame
`timescale 1ns/1ns
`include "burger_config.svh"

module tb_burger_top
	import burger_pkg::*;
;

	localparam int CLK_PERIOD = 10;
	localparam logic [`LAYER_COUNT-1:0][`COORD_W-1:0] COL0_START = `COL0_Y_START;
	localparam logic [`LAYER_COUNT-1:0][`COORD_W-1:0] COL1_START = `COL1_Y_START;

	logic          clk = 1'b0;
	logic          arst_n;
	logic          frame_tick;
	logic [7:0]    keycode;
	logic          on_floor;
	logic          on_ladder;
	chef_pos_t     chef_pos;
	column_state_t column0;
	column_state_t column1;
	logic [7:0]    hex0, hex1, hex2, hex3, hex4, hex5;

	int               fd;
	int               nread;
	int               fields;
	int               line_no;  // data lines done so far
	logic [8*128-1:0] line;
	int               frames, key, floor_lvl, ladder_lvl;
	int               exp_x, exp_y, exp_fall, exp_land;

	always #(CLK_PERIOD / 2) clk = ~clk;

	burger_top u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.keycode    (keycode),
		.on_floor   (on_floor),
		.on_ladder  (on_ladder),
		.chef_pos   (chef_pos),
		.column0    (column0),
		.column1    (column1),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5)
	);

	// ==================================================
	// helpers
	// ==================================================
	task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED at %0t ns: line %0d %s is %0d, expected %0d",
				$time, line_no, what, got, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// waits n rising edges, then 1 ns so drives and samples sit away from the edge
	task automatic step_edges(input int n);
		time t0;
		t0 = $time;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			if ($time - t0 > n * 2 * CLK_PERIOD) begin
				$display("timeout: %0d clock edges did not arrive in time", n);
				$display("Test failed");
				$fatal(1);
			end
		end
		#1;
	endtask

	task automatic run_frame();
		frame_tick = 1'b1;
		step_edges(1);
		frame_tick = 1'b0;  // one clk wide
		step_edges(4);
	endtask

	// standard active-low digit, point dark
	function automatic logic [7:0] seven_seg(input int value);
		case (value & 15)
			0: return 8'hC0;
			1: return 8'hF9;
			2: return 8'hA4;
			3: return 8'hB0;
			4: return 8'h99;
			5: return 8'h92;
			6: return 8'h82;
			7: return 8'hF8;
			8: return 8'h80;
			9: return 8'h90;
			10: return 8'h88;
			11: return 8'h83;
			12: return 8'hC6;
			13: return 8'hA1;
			14: return 8'h86;
			default: return 8'h8E;
		endcase
	endfunction

	function automatic int land_height(input int layer);
		case (layer)
			0: return `LAND_Y0;
			1: return `LAND_Y1;
			2: return `LAND_Y2;
			default: return `LAND_Y3;
		endcase
	endfunction

	task automatic check_outputs(input int x, input int y, input int fall, input int land);
		column_state_t st;
		int            c;
		int            i;
		check("chef x", chef_pos.x, x);
		check("chef y", chef_pos.y, y);
		check("hex0", hex0, seven_seg(x));
		check("hex1", hex1, seven_seg(x >> 4));
		check("hex2", hex2, seven_seg(x >> 8));
		check("hex3", hex3, seven_seg(y));
		check("hex4", hex4, seven_seg(y >> 4));
		check("hex5", hex5, seven_seg(y >> 8));
		check("falling mask", {column1.falling, column0.falling}, fall);
		check("landed mask", {column1.landed, column0.landed}, land);
		for (c = 0; c < 2; c++) begin
			st = (c == 0) ? column0 : column1;
			for (i = 0; i < `LAYER_COUNT; i++) begin
				if (land[c*4+i])
					check("landed layer y", st.layer_y[i], land_height(i));
				else if (!fall[c*4+i])  // resting layers have not moved
					check("resting layer y", st.layer_y[i],
						(c == 0) ? COL0_START[i] : COL1_START[i]);
			end
		end
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		arst_n     = 1'b0;
		frame_tick = 1'b0;
		keycode    = 8'h00;
		on_floor   = 1'b0;
		on_ladder  = 1'b0;
		line_no    = 0;
		step_edges(16);
		arst_n = 1'b1;

		// reset readout is 140 and 190 in hex
		check_outputs(`CHEF_X_START, `CHEF_Y_START, 0, 0);
		check("hex2 reset", hex2, seven_seg(1));
		check("hex1 reset", hex1, seven_seg(4));
		check("hex4 reset", hex4, seven_seg(9));

		fd = $fopen("verif/burger_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file verif/burger_golden.txt");
			$display("Test failed");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			nread = $fgets(line, fd);
			if (nread > 0) begin
				fields = $sscanf(line, "%d %h %d %d %d %d %h %h", frames, key, floor_lvl,
					ladder_lvl, exp_x, exp_y, exp_fall, exp_land);
				if (fields == 8) begin
					line_no++;
					keycode   = key[7:0];
					on_floor  = floor_lvl[0];
					on_ladder = ladder_lvl[0];
					for (int f = 0; f < frames; f++)
						run_frame();
					check_outputs(exp_x, exp_y, exp_fall, exp_land);
				end else if (fields > 0) begin  // comment lines scan as zero fields
					$display("golden line after data line %0d is malformed", line_no);
					$display("Test failed");
					$fatal(1);
				end
			end
		end
		$fclose(fd);

		if (line_no > 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("the golden file held no data lines");
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

//--- verif/burger_golden.txt
# frames keycode on_floor on_ladder | expected chef_x chef_y falling landed (keycode and masks hex)
# mask bits 3:0 are column 0 layers 0..3, bits 7:4 column 1; a move takes effect one frame late
1   00 0 0 320 400 00 00
2   07 0 0 320 400 00 00
3   07 1 0 326 400 00 00
1   04 1 0 328 400 00 00
2   04 0 0 328 400 00 00
10  04 1 0 308 400 00 00
2   1a 1 0 306 400 00 00
5   1a 0 1 306 390 00 00
1   16 0 1 306 388 00 00
40  16 0 1 306 464 00 00
3   2c 1 1 306 464 00 00
240 1a 0 1 306 0   00 00
1   00 0 1 306 0   00 00
160 04 1 0 0   0   00 00
1   07 1 0 0   0   00 00
151 16 0 1 0   300 00 00
1   07 1 0 0   300 00 00
20  07 1 0 40  300 08 00
5   00 0 0 40  300 08 00
12  00 0 0 40  300 08 00
1   00 0 0 40  300 00 08
31  07 1 0 100 300 00 08
1   1a 0 1 100 300 00 08
32  1a 0 1 100 236 00 08
1   07 1 0 100 236 00 08
18  07 1 0 136 236 40 08
1   00 0 0 136 236 40 08
8   00 0 0 136 236 40 08
1   00 0 0 136 236 c0 08
19  00 0 0 136 236 c0 08
1   00 0 0 136 236 80 48
1   00 0 0 136 236 00 c8

//--- filelist.f
+incdir+logic
logic/burger_pkg.sv
logic/keycode_decoder.sv
logic/chef_motion.sv
logic/ingredient_column.sv
logic/hex_display.sv
logic/burger_top.sv
verif/tb_burger_top.sv
